// File: src/vga_pkg.sv
/* shared types and constants for the text-mode VGA generator
   colours are 4 bits per channel; font store is 256 glyphs x 16 rows of 8 pixels
   character store holds 4 rows of 128 codes, addressed as {row, col} */

package vga_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // colours
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  // yellow foreground
  localparam rgb_t FG_COLOR = '{red: 4'hf, green: 4'hf, blue: 4'h0};
  // dark purple background
  localparam rgb_t BG_COLOR = '{red: 4'h2, green: 4'h0, blue: 4'h8};
  localparam rgb_t BLACK    = '{red: 4'h0, green: 4'h0, blue: 4'h0};

  ////////////////////////////////////////////////////////////////////////////
  // raster position, carried down the pixel pipeline
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [15:0] x;
    logic [15:0] y;
    logic        visible;
    logic        hsync_n;
    logic        vsync_n;
  } raster_t;

  // blanked position with syncs inactive
  localparam raster_t RASTER_IDLE = '{x: '0, y: '0, visible: 1'b0,
                                      hsync_n: 1'b1, vsync_n: 1'b1};

  ////////////////////////////////////////////////////////////////////////////
  // host byte decoding
  ////////////////////////////////////////////////////////////////////////////

  // low 7 bits of a command byte, 0x80 and 0x82
  typedef enum logic [6:0] {
    LOAD_FONT  = 7'd0,
    LOAD_CHARS = 7'd2
  } cmd_op_e;

  typedef struct packed {
    logic    is_cmd;
    cmd_op_e op;
  } cmd_word_t;

  // one received byte, read as a command when idle, as data while loading
  typedef union packed {
    cmd_word_t  cmd;
    logic [7:0] data;
  } host_byte_u;

  ////////////////////////////////////////////////////////////////////////////
  // memory geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int FONT_ADDR_W     = 12;
  localparam int CHAR_ADDR_W     = 9;
  localparam int CHAR_ROW_BITS   = 2;
  localparam int CHAR_COL_BITS   = 7;
  localparam int GLYPH_ROWS_LOG2 = 4;
  localparam int GLYPH_COLS_LOG2 = 3;

  // one RAM write port; the character store only looks at the low address bits
  typedef struct packed {
    logic                   en;
    logic [FONT_ADDR_W-1:0] addr;
    logic [7:0]             data;
  } ram_wr_t;

endpackage

// File: src/glyph_ram.sv
/* byte-wide simple dual-port RAM, one cycle read latency
   write port is a ram_wr_t; ADDR_W must not exceed FONT_ADDR_W
   read and write to the same address in one cycle returns the old byte */

module glyph_ram import vga_pkg::*;
#(
  parameter int ADDR_W = CHAR_ADDR_W
)
(
  input  logic              clk,
  input  ram_wr_t           wr,
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [7:0]        rd_data
);

  // block RAM style array, contents undefined until loaded
  logic [7:0] mem [2**ADDR_W];

  // write side, driven by the command receiver
  always_ff @(posedge clk)
  begin
    if (wr.en)
    begin
      mem[wr.addr[ADDR_W-1:0]] <= wr.data;
    end
  end

  // registered read for the video pipeline
  always_ff @(posedge clk)
  begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: src/cmd_receiver.sv
/* four-phase req/ack slave; every byte is acknowledged, unknown commands dropped
   0x80 loads 4096 font bytes, 0x82 loads 512 character codes
   a load cannot be aborted, it always runs to its full length */

module cmd_receiver import vga_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       host_req,
  input  host_byte_u host_data,
  output logic       host_ack,
  output ram_wr_t    font_wr,
  output ram_wr_t    char_wr
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FONT,
    ST_CHARS
  } load_state_e;

  load_state_e            state;
  logic [FONT_ADDR_W-1:0] addr_q;
  host_byte_u             byte_q;
  logic                   byte_vld;
  logic                   new_byte;

  // req seen high while ack still low marks a fresh byte
  assign new_byte = host_req & ~host_ack;

  ////////////////////////////////////////////////////////////////////////////
  // handshake and load FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      host_ack <= 1'b0;
      byte_vld <= 1'b0;
      state    <= ST_IDLE;
      addr_q   <= '0;
    end
    else
    begin
      // ack follows req one cycle late, both edges
      host_ack <= host_req;
      byte_vld <= new_byte;
      if (byte_vld)
      begin
        case (state)
          ST_IDLE:
          begin
            // command view of the byte
            addr_q <= '0;
            if (byte_q.cmd.is_cmd && byte_q.cmd.op == LOAD_FONT)
              state <= ST_FONT;
            else if (byte_q.cmd.is_cmd && byte_q.cmd.op == LOAD_CHARS)
              state <= ST_CHARS;
          end
          ST_FONT:
          begin
            addr_q <= addr_q + 1'b1;
            // last of 4096 glyph rows
            if (addr_q == '1)
              state <= ST_IDLE;
          end
          ST_CHARS:
          begin
            addr_q <= addr_q + 1'b1;
            // last of 512 codes
            if (addr_q[CHAR_ADDR_W-1:0] == '1)
              state <= ST_IDLE;
          end
          default:
            state <= ST_IDLE;
        endcase
      end
    end
  end

  // byte holding register, captured as ack goes up
  always_ff @(posedge clk)
  begin
    if (new_byte)
      byte_q <= host_data;
  end

  ////////////////////////////////////////////////////////////////////////////
  // write ports, data view of the byte
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    font_wr.en   = byte_vld && (state == ST_FONT);
    font_wr.addr = addr_q;
    font_wr.data = byte_q.data;
    char_wr.en   = byte_vld && (state == ST_CHARS);
    char_wr.addr = addr_q;
    char_wr.data = byte_q.data;
  end

  // host must hold req before we answer it
  ack_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(host_ack) |-> $past(host_req));

  // a byte goes to one store only
  one_write_port: assert property (@(posedge clk) disable iff (!arst_n)
    !(font_wr.en && char_wr.en));

endmodule

// File: src/raster_timing.sv
/* free-running raster counters, one pixel per clk
   each line is visible, front porch, sync, back porch; frames likewise in lines
   totals must fit in 16 bits; sync outputs are active low */

module raster_timing import vga_pkg::*;
#(
  parameter int H_VISIBLE = 800,
  parameter int H_FRONT   = 40,
  parameter int H_SYNC    = 128,
  parameter int H_BACK    = 88,
  parameter int V_VISIBLE = 600,
  parameter int V_FRONT   = 1,
  parameter int V_SYNC    = 4,
  parameter int V_BACK    = 23
)
(
  input  logic    clk,
  input  logic    arst_n,
  output raster_t raster
);

  ////////////////////////////////////////////////////////////////////////////
  // derived boundaries
  ////////////////////////////////////////////////////////////////////////////

  localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

  localparam logic [15:0] H_VIS_END  = 16'(H_VISIBLE);
  localparam logic [15:0] H_SYNC_BEG = 16'(H_VISIBLE + H_FRONT);
  localparam logic [15:0] H_SYNC_END = 16'(H_VISIBLE + H_FRONT + H_SYNC);
  localparam logic [15:0] H_LAST     = 16'(H_TOTAL - 1);

  localparam logic [15:0] V_VIS_END  = 16'(V_VISIBLE);
  localparam logic [15:0] V_SYNC_BEG = 16'(V_VISIBLE + V_FRONT);
  localparam logic [15:0] V_SYNC_END = 16'(V_VISIBLE + V_FRONT + V_SYNC);
  localparam logic [15:0] V_LAST     = 16'(V_TOTAL - 1);

  logic [15:0] x_q;
  logic [15:0] y_q;

  ////////////////////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      x_q <= '0;
      y_q <= '0;
    end
    else if (x_q == H_LAST)
    begin
      // end of line, step the line counter
      x_q <= '0;
      if (y_q == V_LAST)
        y_q <= '0;
      else
        y_q <= y_q + 1'b1;
    end
    else
    begin
      x_q <= x_q + 1'b1;
    end
  end

  // position for this cycle, decoded straight from the counters
  always_comb
  begin
    raster.x       = x_q;
    raster.y       = y_q;
    raster.visible = (x_q < H_VIS_END) && (y_q < V_VIS_END);
    // pulses sit right after the front porches
    raster.hsync_n = !((x_q >= H_SYNC_BEG) && (x_q < H_SYNC_END));
    raster.vsync_n = !((y_q >= V_SYNC_BEG) && (y_q < V_SYNC_END));
  end

  x_in_range: assert property (@(posedge clk) disable iff (!arst_n)
    x_q < 16'(H_TOTAL));

endmodule

// File: src/char_fetch.sv
/* two-cycle fetch of the glyph row for each raster position
   expects glyph_ram instances with one cycle registered read on both stores
   only 4 text rows of 128 columns are addressable, the screen repeats beyond */

module char_fetch import vga_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  raster_t                raster_in,
  input  logic [7:0]             char_rd_data,
  input  logic [7:0]             font_rd_data,
  output logic [CHAR_ADDR_W-1:0] char_rd_addr,
  output logic [FONT_ADDR_W-1:0] font_rd_addr,
  output raster_t                raster_out,
  output logic [7:0]             glyph_row
);

  // position that matches the code coming back from the character store
  raster_t raster_s1;
  // position that matches the glyph row coming back from the font store
  raster_t raster_s2;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1, character store lookup
  ////////////////////////////////////////////////////////////////////////////

  // text row is y/16 mod 4, text column is x/8 mod 128
  assign char_rd_addr = {raster_in.y[GLYPH_ROWS_LOG2 +: CHAR_ROW_BITS],
                         raster_in.x[GLYPH_COLS_LOG2 +: CHAR_COL_BITS]};

  ////////////////////////////////////////////////////////////////////////////
  // stage 2, font store lookup
  ////////////////////////////////////////////////////////////////////////////

  // code selects the glyph, y mod 16 the row inside it
  assign font_rd_addr = {char_rd_data, raster_s1.y[GLYPH_ROWS_LOG2-1:0]};

  ////////////////////////////////////////////////////////////////////////////
  // position delay line
  ////////////////////////////////////////////////////////////////////////////

  // tracks the two RAM read latencies so the row and its position stay paired
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      raster_s1 <= RASTER_IDLE;
      raster_s2 <= RASTER_IDLE;
    end
    else
    begin
      raster_s1 <= raster_in;
      raster_s2 <= raster_s1;
    end
  end

  assign raster_out = raster_s2;

  // font store output already sits in its read register
  assign glyph_row = font_rd_data;

endmodule

// File: src/pixel_colorizer.sv
/* last pipeline stage, adds one cycle of latency to colour and syncs
   bit 7 of the glyph row is the leftmost pixel of a character cell */

module pixel_colorizer import vga_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  raster_t    raster_in,
  input  logic [7:0] glyph_row,
  output rgb_t       rgb,
  output logic       hsync_n,
  output logic       vsync_n,
  output logic       de
);

  logic [GLYPH_COLS_LOG2-1:0] bit_sel;
  logic                       pix_on;
  rgb_t                       color;

  ////////////////////////////////////////////////////////////////////////////
  // colour pick
  ////////////////////////////////////////////////////////////////////////////

  // 7 - (x mod 8)
  assign bit_sel = ~raster_in.x[GLYPH_COLS_LOG2-1:0];
  assign pix_on  = glyph_row[bit_sel];

  always_comb
  begin
    if (!raster_in.visible)
      color = BLACK;
    else if (pix_on)
      color = FG_COLOR;
    else
      color = BG_COLOR;
  end

  // output register, syncs and de kept in step with the colour
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rgb     <= BLACK;
      hsync_n <= 1'b1;
      vsync_n <= 1'b1;
      de      <= 1'b0;
    end
    else
    begin
      rgb     <= color;
      hsync_n <= raster_in.hsync_n;
      vsync_n <= raster_in.vsync_n;
      de      <= raster_in.visible;
    end
  end

endmodule

// File: src/text_vga_top.sv
/* text-mode VGA pixel generator, loaded over a byte-wide req/ack handshake
   outputs lag the raster counters by 3 clk; timing counts are in pixels and lines */

module text_vga_top import vga_pkg::*;
#(
  parameter int H_VISIBLE = 800,
  parameter int H_FRONT   = 40,
  parameter int H_SYNC    = 128,
  parameter int H_BACK    = 88,
  parameter int V_VISIBLE = 600,
  parameter int V_FRONT   = 1,
  parameter int V_SYNC    = 4,
  parameter int V_BACK    = 23
)
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       host_req,
  input  host_byte_u host_data,
  output logic       host_ack,
  output rgb_t       rgb,
  output logic       hsync_n,
  output logic       vsync_n,
  output logic       de
);

  ram_wr_t                font_wr;
  ram_wr_t                char_wr;
  logic [CHAR_ADDR_W-1:0] char_rd_addr;
  logic [FONT_ADDR_W-1:0] font_rd_addr;
  logic [7:0]             char_rd_data;
  logic [7:0]             font_rd_data;
  raster_t                raster_gen;
  raster_t                raster_fetch;
  logic [7:0]             glyph_row;

  ////////////////////////////////////////////////////////////////////////////
  // host side, loader and the two stores
  ////////////////////////////////////////////////////////////////////////////

  cmd_receiver i_cmd_receiver (
    .clk       (clk),
    .arst_n    (arst_n),
    .host_req  (host_req),
    .host_data (host_data),
    .host_ack  (host_ack),
    .font_wr   (font_wr),
    .char_wr   (char_wr)
  );

  // 256 glyphs x 16 rows
  glyph_ram #(.ADDR_W(FONT_ADDR_W)) font_ram (
    .clk     (clk),
    .wr      (font_wr),
    .rd_addr (font_rd_addr),
    .rd_data (font_rd_data)
  );

  // 4 text rows x 128 columns
  glyph_ram #(.ADDR_W(CHAR_ADDR_W)) char_ram (
    .clk     (clk),
    .wr      (char_wr),
    .rd_addr (char_rd_addr),
    .rd_data (char_rd_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // video pipeline
  ////////////////////////////////////////////////////////////////////////////

  raster_timing #(
    .H_VISIBLE (H_VISIBLE),
    .H_FRONT   (H_FRONT),
    .H_SYNC    (H_SYNC),
    .H_BACK    (H_BACK),
    .V_VISIBLE (V_VISIBLE),
    .V_FRONT   (V_FRONT),
    .V_SYNC    (V_SYNC),
    .V_BACK    (V_BACK)
  ) i_raster_timing (
    .clk    (clk),
    .arst_n (arst_n),
    .raster (raster_gen)
  );

  char_fetch i_char_fetch (
    .clk          (clk),
    .arst_n       (arst_n),
    .raster_in    (raster_gen),
    .char_rd_data (char_rd_data),
    .font_rd_data (font_rd_data),
    .char_rd_addr (char_rd_addr),
    .font_rd_addr (font_rd_addr),
    .raster_out   (raster_fetch),
    .glyph_row    (glyph_row)
  );

  pixel_colorizer i_pixel_colorizer (
    .clk       (clk),
    .arst_n    (arst_n),
    .raster_in (raster_fetch),
    .glyph_row (glyph_row),
    .rgb       (rgb),
    .hsync_n   (hsync_n),
    .vsync_n   (vsync_n),
    .de        (de)
  );

endmodule

// File: testbench/tb_text_vga.sv
/* self-checking testbench for text_vga_top on a small 160x64 raster
   font and character contents come from an LFSR, expected pixels from local copies
   only DUT outputs are observed; screen position is rebuilt from de and vsync_n */

module tb_text_vga import vga_pkg::*;
();

  localparam int H_VISIBLE    = 160;
  localparam int H_FRONT      = 8;
  localparam int H_SYNC       = 16;
  localparam int H_BACK       = 8;
  localparam int V_VISIBLE    = 64;
  localparam int V_FRONT      = 2;
  localparam int V_SYNC       = 2;
  localparam int V_BACK       = 2;
  localparam int H_TOTAL      = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL      = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int ACK_TIMEOUT  = 20;
  localparam int DRIVE_DELAY  = 10;

  // one behaviour: optional ignored bytes, optional load, optional screen probe
  typedef struct packed {
    logic       send_ignored;
    logic [7:0] load_cmd;
    logic       check_screen;
  } step_t;

  typedef struct packed {
    int col;
    int line;
  } probe_t;

  localparam int NUM_STEPS = 4;
  localparam step_t STEPS [NUM_STEPS] = '{
    // reset state, sync pulse widths over whole frames
    '{send_ignored: 1'b0, load_cmd: 8'h00, check_screen: 1'b0},
    // 0x81 and 0x05 dropped, then the font load
    '{send_ignored: 1'b1, load_cmd: 8'h80, check_screen: 1'b0},
    // character load, first screen check
    '{send_ignored: 1'b0, load_cmd: 8'h82, check_screen: 1'b1},
    // character reload only, font unchanged
    '{send_ignored: 1'b0, load_cmd: 8'h82, check_screen: 1'b1}
  };

  // corners, cell edges and every text row
  localparam int NUM_PROBES = 16;
  localparam probe_t PROBES [NUM_PROBES] = '{
    '{0, 0}, '{7, 0}, '{8, 0}, '{159, 0},
    '{24, 5}, '{3, 15}, '{12, 16}, '{100, 17},
    '{45, 31}, '{64, 32}, '{127, 40}, '{158, 47},
    '{1, 48}, '{80, 55}, '{153, 63}, '{159, 63}
  };

  logic       clk;
  logic       arst_n;
  logic       host_req;
  host_byte_u host_data;
  logic       host_ack;
  rgb_t       rgb;
  logic       hsync_n;
  logic       vsync_n;
  logic       de;

  // testbench copies of both stores
  logic [7:0]  font_model [4096];
  logic [7:0]  char_model [512];
  logic [15:0] lfsr_state;

  // last captured visible frame, filled by the output monitor
  rgb_t frame_pix [V_VISIBLE][H_VISIBLE];

  int   line_idx    = -1;
  int   px_idx      = 0;
  int   hs_low      = 0;
  int   vs_low      = 0;
  int   hs_falls    = 0;
  int   frames_done = 0;
  logic in_frame    = 1'b0;
  logic de_q        = 1'b0;
  logic hs_q        = 1'b1;
  logic vs_q        = 1'b1;

  text_vga_top #(
    .H_VISIBLE (H_VISIBLE),
    .H_FRONT   (H_FRONT),
    .H_SYNC    (H_SYNC),
    .H_BACK    (H_BACK),
    .V_VISIBLE (V_VISIBLE),
    .V_FRONT   (V_FRONT),
    .V_SYNC    (V_SYNC),
    .V_BACK    (V_BACK)
  ) i_text_vga_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .host_req  (host_req),
    .host_data (host_data),
    .host_ack  (host_ack),
    .rgb       (rgb),
    .hsync_n   (hsync_n),
    .vsync_n   (vsync_n),
    .de        (de)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // failure reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Error at time %0t: %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: gave up waiting for %s", what);
    stop_with_failure();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1, shifting toward the msb
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one LFSR step per bit taken
  task automatic next_random_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  // full four-phase handshake for one byte
  task automatic send_byte(input logic [7:0] value);
    int waited;
    @(posedge clk);
    #DRIVE_DELAY;
    host_data.data = value;
    host_req = 1'b1;
    waited = 0;
    while (!host_ack)
    begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
      if (waited > ACK_TIMEOUT)
        report_timeout("host_ack to rise");
    end
    host_req = 1'b0;
    waited = 0;
    while (host_ack)
    begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
      if (waited > ACK_TIMEOUT)
        report_timeout("host_ack to fall");
    end
  endtask

  // command byte then the whole store, mirrored into the local copy
  task automatic load_memory(input logic [7:0] cmd);
    logic [7:0] value;
    int         count;
    count = (cmd == 8'h80) ? 4096 : 512;
    send_byte(cmd);
    for (int i = 0; i < count; i++)
    begin
      next_random_byte(value);
      if (cmd == 8'h80)
        font_model[i] = value;
      else
        char_model[i] = value;
      send_byte(value);
    end
  endtask

  task automatic wait_frames(input int count);
    int target;
    int waited;
    target = frames_done + count;
    waited = 0;
    while (frames_done < target)
    begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
      if (waited > (count + 1) * FRAME_CYCLES)
        report_timeout("a complete frame on de and vsync_n");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model and screen probes
  ////////////////////////////////////////////////////////////////////////////

  // code from {text row mod 4, text column mod 128}, glyph row from {code, line mod 16}
  function automatic rgb_t expected_color(input int col, input int line);
    int         char_idx;
    int         font_idx;
    logic [7:0] row_bits;
    char_idx = ((line / 16) % 4) * 128 + (col / 8) % 128;
    font_idx = int'(char_model[char_idx]) * 16 + line % 16;
    row_bits = font_model[font_idx];
    // bit 7 is the leftmost pixel
    if (row_bits[7 - col % 8])
      return FG_COLOR;
    else
      return BG_COLOR;
  endfunction

  task automatic check_screen();
    int col;
    int line;
    for (int p = 0; p < NUM_PROBES; p++)
    begin
      col  = PROBES[p].col;
      line = PROBES[p].line;
      check_value($sformatf("rgb at column %0d line %0d", col, line),
                  32'(expected_color(col, line)), 32'(frame_pix[line][col]));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output monitor, sampled on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (arst_n)
    begin
      if (!de)
        check_value("rgb while de low", 32'(BLACK), 32'(rgb));
      // sync pulse widths
      if (!hsync_n)
        hs_low = hs_low + 1;
      if (!vsync_n)
        vs_low = vs_low + 1;
      if (hsync_n && !hs_q)
      begin
        check_value("hsync_n low cycles", H_SYNC, hs_low);
        hs_low = 0;
      end
      if (!hsync_n && hs_q)
        hs_falls = hs_falls + 1;
      // frame opens when vsync_n goes back high
      if (vsync_n && !vs_q)
      begin
        check_value("vsync_n low cycles", V_SYNC * H_TOTAL, vs_low);
        vs_low   = 0;
        in_frame = 1'b1;
        line_idx = -1;
      end
      // frame closes at the next vsync pulse
      if (!vsync_n && vs_q)
      begin
        if (in_frame)
        begin
          check_value("de lines per frame", V_VISIBLE, line_idx + 1);
          check_value("hsync pulses per frame", V_TOTAL, hs_falls);
          frames_done = frames_done + 1;
        end
        hs_falls = 0;
        in_frame = 1'b0;
      end
      if (de && !de_q)
      begin
        line_idx = line_idx + 1;
        px_idx   = 0;
      end
      if (de)
      begin
        if (in_frame && line_idx >= 0 && line_idx < V_VISIBLE && px_idx < H_VISIBLE)
          frame_pix[line_idx][px_idx] = rgb;
        px_idx = px_idx + 1;
      end
      if (!de && de_q)
        check_value("de pixels per line", H_VISIBLE, px_idx);
      de_q = de;
      hs_q = hsync_n;
      vs_q = vsync_n;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence, one pass per table entry
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    arst_n     = 1'b0;
    host_req   = 1'b0;
    host_data  = '0;
    lfsr_state = 16'd35;
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b1;
    for (int s = 0; s < NUM_STEPS; s++)
    begin
      // between bytes the receiver must be idle with ack low
      check_value("host_ack", 32'd0, 32'(host_ack));
      if (STEPS[s].send_ignored)
      begin
        send_byte(8'h81);
        send_byte(8'h05);
      end
      if (STEPS[s].load_cmd != 8'h00)
        load_memory(STEPS[s].load_cmd);
      // second frame end guarantees a frame drawn wholly after the load
      wait_frames(2);
      if (STEPS[s].check_screen)
        check_screen();
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: project.f
src/vga_pkg.sv
src/glyph_ram.sv
src/cmd_receiver.sv
src/raster_timing.sv
src/char_fetch.sv
src/pixel_colorizer.sv
src/text_vga_top.sv
testbench/tb_text_vga.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_text_vga
FILELIST  = project.f
SIM_BIN   = obj_dir/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
